//--- filelist.f
+incdir+include
design/usiBusPkg.sv
design/spiCsrPkg.sv
design/spiCsr.sv
design/ckeGenerator.sv
design/spiMasterEngine.sv
design/spiSlaveFrame.sv
design/spiBusBridge.sv
design/spiSignal.sv
design/spiBlock.sv
verification/spiBlockTb.sv

//--- include/spiBlockTests.svh
`ifndef spiBlockTestsSvh
`define spiBlockTestsSvh

	//--------------------------------------------------
	// Checks and reporting
	//--------------------------------------------------
	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected) else begin
			errors++;
			$display("MISMATCH %s: got %h expected %h", name, got, expected);
		end
	endtask

	task automatic checkTrue(input logic cond, input string what);
		assert (cond === 1'b1) else begin
			errors++;
			$display("ERROR %s", what);
		end
	endtask

	task automatic reportTest(input string name, input int startErrors);
		testCount++;
		if (errors == startErrors) begin
			$display("%s: ok", name);
		end else begin
			failedTests++;
			$display("%s: %0d errors", name, errors - startErrors);
		end
	endtask

	task automatic waitCycles(input int n);
		repeat (n) @(negedge sClk);
	endtask

	//--------------------------------------------------
	// Bus slave side drivers
	//--------------------------------------------------
	// Address word with request, direction, block and offset
	function automatic logic [31:0] csrWord(input logic [7:0] block,
		input logic [7:0] offset, input logic write);
		logic [31:0] word;
		word = '0;
		word[usiBusPkg::reqBit] = 1'b1;
		word[usiBusPkg::wrBit] = write;
		word[usiBusPkg::blockLsb +: usiBusPkg::blockWidth] = block;
		word[usiBusPkg::csrLsb +: usiBusPkg::csrWidth] = offset;
		return word;
	endfunction

	task automatic busWrite(input logic [7:0] offset, input logic [31:0] data);
		@(negedge sClk);
		csrAdrs = csrWord(usiBusPkg::blockId, offset, 1'b1);
		csrWrData = data;
		@(negedge sClk);
		csrAdrs = '0;
		csrWrData = '0;
	endtask

	// Data is registered, so it shows one cycle after the request
	task automatic busRead(input logic [7:0] offset, input logic [7:0] block,
		output logic [31:0] value);
		@(negedge sClk);
		csrAdrs = csrWord(block, offset, 1'b0);
		@(negedge sClk);
		csrAdrs = '0;
		value = csrRdData;
	endtask

	task automatic setDirection(input logic level);
		int cycles;
		@(negedge sClk);
		spiDir = level;
		cycles = 0;
		while (dirMaster !== level && cycles < 5) begin
			@(negedge sClk);
			cycles++;
		end
		checkTrue(dirMaster === level, "dirMaster did not follow the direction pin");
		checkValue("dirMasterN", dirMasterN, {31'h0, ~level});
	endtask

	task automatic waitIntr();
		int cycles;
		cycles = 0;
		while (intr !== 1'b1 && cycles < 32 * (masterDiv + 1)) begin
			@(negedge sClk);
			cycles++;
		end
		checkTrue(intr, "intr did not rise after the transfer");
	endtask

	//--------------------------------------------------
	// Slave side SPI drivers, mode 0
	//--------------------------------------------------
	task automatic openFrame();
		@(negedge sClk);
		slaveCs = 1'b0;
		waitCycles(slaveHalf);
	endtask

	task automatic closeFrame();
		slaveSck = 1'b0;
		waitCycles(slaveHalf);
		slaveCs = 1'b1;
		waitCycles(slaveHalf);
	endtask

	// MISO is taken just ahead of each rising edge
	task automatic exchangeByte(input logic [7:0] txByte, output logic [7:0] rxByte);
		for (int i = 7; i >= 0; i--) begin
			slaveSck = 1'b0;
			slaveMosi = txByte[i];
			waitCycles(slaveHalf);
			rxByte[i] = slaveMiso;
			slaveSck = 1'b1;
			waitCycles(slaveHalf);
		end
	endtask

	task automatic sendWriteFrame(input logic [15:0] adrs, input logic [31:0] word);
		logic [7:0] unused;
		openFrame();
		exchangeByte(spiCsrPkg::cmdWrite, unused);
		exchangeByte(adrs[15:8], unused);
		exchangeByte(adrs[7:0], unused);
		for (int i = 3; i >= 0; i--) begin
			exchangeByte(word[8*i +: 8], unused);
		end
		closeFrame();
	endtask

	//--------------------------------------------------
	// Directed tests
	//--------------------------------------------------
	task automatic resetAndRegisters();
		int startErrors;
		logic [31:0] value;
		logic [15:0] divVal;
		startErrors = errors;
		checkValue("intr", intr, 0);
		checkValue("masterCs", masterCs, 1);
		checkValue("dirMasterN", dirMasterN, 1);
		busWrite(spiCsrPkg::csrCtrl, 32'h1);
		busRead(spiCsrPkg::csrCtrl, usiBusPkg::blockId, value);
		checkValue("csrRdData ctrl", value, 32'h1);
		// Read data lasts one cycle
		@(negedge sClk);
		checkValue("csrRdData after read", csrRdData, 0);
		divVal = 16'($random(seed));
		busWrite(spiCsrPkg::csrDiv, {16'h0, divVal});
		busRead(spiCsrPkg::csrDiv, usiBusPkg::blockId, value);
		checkValue("csrRdData div", value, {16'h0, divVal});
		busWrite(spiCsrPkg::csrCs, 32'h0);
		busRead(spiCsrPkg::csrCs, usiBusPkg::blockId, value);
		checkValue("csrRdData cs", value, 32'h0);
		busWrite(spiCsrPkg::csrCs, 32'h1);
		// Another block's select value
		busRead(spiCsrPkg::csrCtrl, 8'h05, value);
		checkValue("csrRdData other block", value, 0);
		// Counter picks up the new divider while disabled
		busWrite(spiCsrPkg::csrCtrl, 32'h0);
		busWrite(spiCsrPkg::csrDiv, masterDiv);
		busWrite(spiCsrPkg::csrCtrl, 32'h1);
		reportTest("reset and registers", startErrors);
	endtask

	task automatic masterTransfer();
		int startErrors;
		int periodCycles;
		logic [7:0] txByte;
		logic [31:0] value;
		startErrors = errors;
		setDirection(1'b1);
		busWrite(spiCsrPkg::csrCs, 32'h0);
		txByte = 8'($random(seed));
		riseCount = 0;
		busWrite(spiCsrPkg::csrTx, {24'h0, txByte});
		waitIntr();
		checkValue("masterMosi bits", mosiBits, txByte);
		checkValue("masterSck rising edges", riseCount, 8);
		// Seven periods between first and last rise
		periodCycles = $rtoi((lastRise - firstRise) / (7.0 * clkNs) + 0.5);
		checkValue("masterSck period cycles", periodCycles, 2 * (masterDiv + 1));
		busRead(spiCsrPkg::csrRx, usiBusPkg::blockId, value);
		checkValue("csrRx", value, devByte);
		busWrite(spiCsrPkg::csrCs, 32'h1);
		reportTest("master transfer", startErrors);
	endtask

	task automatic doneClearing();
		int startErrors;
		int tries;
		logic [7:0] byteA;
		logic [31:0] status;
		logic [31:0] value;
		startErrors = errors;
		busWrite(spiCsrPkg::csrCs, 32'h0);
		byteA = 8'($random(seed));
		riseCount = 0;
		busWrite(spiCsrPkg::csrTx, {24'h0, byteA});
		tries = 0;
		status = '0;
		while (!status[1] && tries < 20) begin
			busRead(spiCsrPkg::csrStatus, usiBusPkg::blockId, status);
			tries++;
		end
		checkTrue(status[1], "status never reported busy after a csrTx write");
		// Second byte must be dropped
		busWrite(spiCsrPkg::csrTx, {24'h0, ~byteA});
		waitIntr();
		waitCycles(8 * (masterDiv + 1));
		checkValue("masterMosi bits", mosiBits, byteA);
		checkValue("masterSck rising edges", riseCount, 8);
		busRead(spiCsrPkg::csrTx, usiBusPkg::blockId, value);
		checkValue("csrTx", value, {24'h0, byteA});
		busRead(spiCsrPkg::csrRx, usiBusPkg::blockId, value);
		checkValue("csrRx", value, devByte);
		checkValue("intr after csrRx read", intr, 0);
		busWrite(spiCsrPkg::csrCs, 32'h1);
		reportTest("done clearing", startErrors);
	endtask

	task automatic slaveWrite();
		int startErrors;
		logic [15:0] adrs;
		logic [31:0] word;
		logic [31:0] expAdrs;
		startErrors = errors;
		setDirection(1'b0);
		adrs = 16'($random(seed));
		word = $random(seed);
		wrCount = 0;
		rdCount = 0;
		sendWriteFrame(adrs, word);
		expAdrs = '0;
		expAdrs[usiBusPkg::reqBit] = 1'b1;
		expAdrs[usiBusPkg::wrBit] = 1'b1;
		expAdrs[15:0] = adrs;
		checkValue("write strobe count", wrCount, 1);
		checkValue("read strobe count", rdCount, 0);
		checkValue("masterAdrs", lastAdrs, expAdrs);
		checkValue("masterWrData", lastWrData, word);
		reportTest("slave write", startErrors);
	endtask

	task automatic slaveRead();
		int startErrors;
		logic [15:0] adrs;
		logic [7:0] rxByte;
		logic [31:0] rxWord;
		logic [31:0] expected;
		logic [31:0] expAdrs;
		startErrors = errors;
		adrs = 16'($random(seed));
		expected = mem[adrs];
		wrCount = 0;
		rdCount = 0;
		openFrame();
		exchangeByte(spiCsrPkg::cmdRead, rxByte);
		exchangeByte(adrs[15:8], rxByte);
		exchangeByte(adrs[7:0], rxByte);
		rxWord = '0;
		for (int i = 0; i < spiCsrPkg::dataBytes; i++) begin
			exchangeByte(8'h00, rxByte);
			rxWord = {rxWord[23:0], rxByte};
		end
		closeFrame();
		expAdrs = '0;
		expAdrs[usiBusPkg::reqBit] = 1'b1;
		expAdrs[15:0] = adrs;
		checkValue("read strobe count", rdCount, 1);
		checkValue("write strobe count", wrCount, 0);
		checkValue("masterAdrs", lastAdrs, expAdrs);
		checkValue("slaveMiso word", rxWord, expected);
		reportTest("slave read", startErrors);
	endtask

	task automatic directionGating();
		int startErrors;
		logic idle;
		startErrors = errors;
		// Direction still low here
		busWrite(spiCsrPkg::csrCs, 32'h0);
		riseCount = 0;
		busWrite(spiCsrPkg::csrTx, $random(seed));
		idle = 1'b1;
		repeat (60) begin
			@(negedge sClk);
			if (masterSck !== 1'b0 || masterMosi !== 1'b0 || masterCs !== 1'b1) begin
				idle = 1'b0;
			end
		end
		checkTrue(idle, "master pins left their idle levels while direction was low");
		checkValue("masterSck rising edges", riseCount, 0);
		// Master mode, slave frames ignored
		setDirection(1'b1);
		wrCount = 0;
		rdCount = 0;
		sendWriteFrame(16'($random(seed)), $random(seed));
		checkValue("write strobe count", wrCount, 0);
		checkValue("read strobe count", rdCount, 0);
		busWrite(spiCsrPkg::csrCs, 32'h1);
		reportTest("direction gating", startErrors);
	endtask

`endif

//--- verification/spiBlockTb.sv
`timescale 1ns/1ps

module spiBlockTb;

	//--------------------------------------------------
	// Bench timing
	//--------------------------------------------------
	localparam int clkNs = 8;
	localparam int masterDiv = 3;
	// Slave SCK half period in sClk cycles
	localparam int slaveHalf = 8;
	// Byte the flash model shifts back
	localparam logic [7:0] devByte = 8'hC6;

	// Three slave frames and two master bytes, doubled, plus register traffic
	localparam int frameBits = 8 * (1 + spiCsrPkg::adrsBytes + spiCsrPkg::dataBytes);
	localparam int slaveNs = 3 * frameBits * 2 * slaveHalf * clkNs;
	localparam int masterNs = 2 * 8 * 2 * (masterDiv + 1) * clkNs;
	localparam int watchdogNs = 2 * (slaveNs + masterNs) + 400 * clkNs;

	logic sClk;
	logic reset;
	logic spiDir;
	logic slaveSck;
	logic slaveMosi;
	logic slaveCs;
	logic slaveMiso;
	logic masterMiso;
	logic masterSck;
	logic masterMosi;
	logic masterCs;
	logic [31:0] csrAdrs;
	logic [31:0] csrWrData;
	logic [31:0] csrRdData;
	logic [31:0] masterRdData;
	logic [31:0] masterAdrs;
	logic [31:0] masterWrData;
	logic intr;
	logic dirMaster;
	logic dirMasterN;

	// Run bookkeeping
	integer seed;
	int errors;
	int testCount;
	int failedTests;

	// Bus memory model state
	logic [31:0] mem [0:65535];
	int wrCount;
	int rdCount;
	logic [31:0] lastAdrs;
	logic [31:0] lastWrData;

	// Flash model and MOSI monitor
	logic [7:0] devShift;
	logic [7:0] mosiBits;
	int riseCount;
	realtime firstRise;
	realtime lastRise;

	spiBlock spiBlock_i (
		.sClk(sClk),
		.reset(reset),
		.spiDir(spiDir),
		.slaveSck(slaveSck),
		.slaveMosi(slaveMosi),
		.slaveCs(slaveCs),
		.slaveMiso(slaveMiso),
		.masterMiso(masterMiso),
		.masterSck(masterSck),
		.masterMosi(masterMosi),
		.masterCs(masterCs),
		.csrAdrs(csrAdrs),
		.csrWrData(csrWrData),
		.csrRdData(csrRdData),
		.masterRdData(masterRdData),
		.masterAdrs(masterAdrs),
		.masterWrData(masterWrData),
		.intr(intr),
		.dirMaster(dirMaster),
		.dirMasterN(dirMasterN)
	);

	`include "spiBlockTests.svh"

	always #(clkNs / 2) sClk = ~sClk;

	//--------------------------------------------------
	// Bus memory, answers one cycle after a read
	//--------------------------------------------------
	always @(posedge sClk) begin
		if (masterAdrs[usiBusPkg::reqBit]) begin
			lastAdrs <= masterAdrs;
			if (masterAdrs[usiBusPkg::wrBit]) begin
				mem[masterAdrs[15:0]] <= masterWrData;
				lastWrData <= masterWrData;
				wrCount <= wrCount + 1;
			end else begin
				masterRdData <= mem[masterAdrs[15:0]];
				rdCount <= rdCount + 1;
			end
		end
	end

	//--------------------------------------------------
	// Flash device on the master pins
	//--------------------------------------------------
	// Rotates on SCK falls, reloads while deselected
	always @(negedge masterSck or posedge masterCs) begin
		if (masterCs) begin
			devShift <= devByte;
		end else begin
			devShift <= {devShift[6:0], devShift[7]};
		end
	end

	assign masterMiso = devShift[7];

	// MOSI as a mode-0 slave sees it
	always @(posedge masterSck) begin
		mosiBits <= {mosiBits[6:0], masterMosi};
		if (riseCount == 0) begin
			firstRise <= $realtime;
		end
		lastRise <= $realtime;
		riseCount <= riseCount + 1;
	end

	// Watchdog
	initial begin
		#(watchdogNs);
		$display("Watchdog expired after %0d ns, run stopped", watchdogNs);
		$display("=== FAIL ===");
		$finish;
	end

	//--------------------------------------------------
	// Main sequence
	//--------------------------------------------------
	initial begin
		seed = 32'ha1c35623;
		errors = 0;
		testCount = 0;
		failedTests = 0;
		sClk = 1'b0;
		reset = 1'b1;
		spiDir = 1'b0;
		slaveSck = 1'b0;
		slaveMosi = 1'b0;
		slaveCs = 1'b1;
		csrAdrs = '0;
		csrWrData = '0;
		masterRdData = '0;
		wrCount = 0;
		rdCount = 0;
		riseCount = 0;
		devShift = devByte;
		// Fill value mixes every address bit
		for (int i = 0; i < 65536; i++) begin
			mem[i] = {16'(i) ^ 16'h3C5A, ~16'(i)};
		end
		repeat (3) @(posedge sClk);
		@(negedge sClk);
		reset = 1'b0;

		resetAndRegisters();
		masterTransfer();
		doneClearing();
		slaveWrite();
		slaveRead();
		directionGating();

		$display("Tests run %0d, tests failed %0d, checks failed %0d",
			testCount, failedTests, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- design/spiBlock.sv
`timescale 1ns/1ps

module spiBlock (
	input  logic sClk,
	input  logic reset,
	input  logic spiDir,
	// External SPI pins
	input  logic slaveSck,
	input  logic slaveMosi,
	input  logic slaveCs,
	output logic slaveMiso,
	input  logic masterMiso,
	output logic masterSck,
	output logic masterMosi,
	output logic masterCs,
	// Bus slave side
	input  logic [usiBusPkg::busWidth-1:0] csrAdrs,
	input  logic [usiBusPkg::busWidth-1:0] csrWrData,
	output logic [usiBusPkg::busWidth-1:0] csrRdData,
	// Bus master side
	input  logic [usiBusPkg::busWidth-1:0] masterRdData,
	output logic [usiBusPkg::busWidth-1:0] masterAdrs,
	output logic [usiBusPkg::busWidth-1:0] masterWrData,
	output logic intr,
	output logic dirMaster,
	output logic dirMasterN
);

	//--------------------------------------------------
	// Register file to master engine
	//--------------------------------------------------
	logic spiEn;
	logic [spiCsrPkg::divWidth-1:0] spiDiv;
	logic [7:0] txData;
	logic txStart;
	logic csLevel;
	logic [7:0] rxData;
	logic doneStrobe;
	logic busy;
	logic cke;

	// Slave frames to bridge
	logic [7:0] byteData;
	logic byteStrobe;
	logic frameStart;
	logic [usiBusPkg::busWidth-1:0] rdWord;
	logic rdLoad;

	spiCsr spiCsr_i (
		.sClk(sClk),
		.reset(reset),
		.csrAdrs(csrAdrs),
		.csrWrData(csrWrData),
		.csrRdData(csrRdData),
		.rxData(rxData),
		.doneStrobe(doneStrobe),
		.busy(busy),
		.spiEn(spiEn),
		.spiDiv(spiDiv),
		.txData(txData),
		.txStart(txStart),
		.csLevel(csLevel),
		.intr(intr)
	);

	ckeGenerator ckeGenerator_i (
		.sClk(sClk),
		.reset(reset),
		.spiEn(spiEn),
		.spiDiv(spiDiv),
		.cke(cke)
	);

	//--------------------------------------------------
	// Pin handling and bus bridge
	//--------------------------------------------------
	spiSignal spiSignal_i (
		.sClk(sClk),
		.reset(reset),
		.spiDir(spiDir),
		.slaveSck(slaveSck),
		.slaveMosi(slaveMosi),
		.slaveCs(slaveCs),
		.slaveMiso(slaveMiso),
		.masterMiso(masterMiso),
		.masterSck(masterSck),
		.masterMosi(masterMosi),
		.masterCs(masterCs),
		.dirMaster(dirMaster),
		.dirMasterN(dirMasterN),
		.cke(cke),
		.txStart(txStart),
		.txData(txData),
		.csLevel(csLevel),
		.rxData(rxData),
		.doneStrobe(doneStrobe),
		.busy(busy),
		.rdWord(rdWord),
		.rdLoad(rdLoad),
		.byteData(byteData),
		.byteStrobe(byteStrobe),
		.frameStart(frameStart)
	);

	spiBusBridge spiBusBridge_i (
		.sClk(sClk),
		.reset(reset),
		.byteData(byteData),
		.byteStrobe(byteStrobe),
		.frameStart(frameStart),
		.masterRdData(masterRdData),
		.masterAdrs(masterAdrs),
		.masterWrData(masterWrData),
		.rdWord(rdWord),
		.rdLoad(rdLoad)
	);

endmodule

//--- design/spiSignal.sv
`timescale 1ns/1ps

module spiSignal (
	input  logic sClk,
	input  logic reset,
	input  logic spiDir,
	// Slave pins
	input  logic slaveSck,
	input  logic slaveMosi,
	input  logic slaveCs,
	output logic slaveMiso,
	// Master pins
	input  logic masterMiso,
	output logic masterSck,
	output logic masterMosi,
	output logic masterCs,
	output logic dirMaster,
	output logic dirMasterN,
	// Master side control
	input  logic cke,
	input  logic txStart,
	input  logic [7:0] txData,
	input  logic csLevel,
	output logic [7:0] rxData,
	output logic doneStrobe,
	output logic busy,
	// Slave side frames
	input  logic [usiBusPkg::busWidth-1:0] rdWord,
	input  logic rdLoad,
	output logic [7:0] byteData,
	output logic byteStrobe,
	output logic frameStart
);

	logic [1:0] dirSync;
	logic engineSck;
	logic engineMosi;
	logic frameMiso;

	//--------------------------------------------------
	// Direction sync, high is master
	//--------------------------------------------------
	always_ff @(posedge sClk) begin
		if (reset) begin
			dirSync <= '0;
		end else begin
			dirSync <= {dirSync[0], spiDir};
		end
	end

	assign dirMaster = dirSync[1];
	assign dirMasterN = !dirSync[1];

	// Idle levels on the unused pin set
	assign masterSck = dirMaster && engineSck;
	assign masterMosi = dirMaster && engineMosi;
	assign masterCs = !dirMaster || csLevel;
	assign slaveMiso = !dirMaster && frameMiso;

	//--------------------------------------------------
	// Engines
	//--------------------------------------------------
	spiMasterEngine spiMasterEngine_i (
		.sClk(sClk),
		.reset(reset),
		.cke(cke),
		.txStart(txStart && dirMaster),
		.txData(txData),
		.miso(masterMiso),
		.sck(engineSck),
		.mosi(engineMosi),
		.rxData(rxData),
		.doneStrobe(doneStrobe),
		.busy(busy)
	);

	spiSlaveFrame spiSlaveFrame_i (
		.sClk(sClk),
		.reset(reset),
		.sck(slaveSck),
		.mosi(slaveMosi),
		.cs(slaveCs),
		.active(dirMasterN),
		.rdWord(rdWord),
		.rdLoad(rdLoad),
		.miso(frameMiso),
		.byteData(byteData),
		.byteStrobe(byteStrobe),
		.frameStart(frameStart)
	);

endmodule

//--- design/spiBusBridge.sv
`timescale 1ns/1ps

module spiBusBridge (
	input  logic sClk,
	input  logic reset,
	input  logic [7:0] byteData,
	input  logic byteStrobe,
	input  logic frameStart,
	input  logic [usiBusPkg::busWidth-1:0] masterRdData,
	output logic [usiBusPkg::busWidth-1:0] masterAdrs,
	output logic [usiBusPkg::busWidth-1:0] masterWrData,
	output logic [usiBusPkg::busWidth-1:0] rdWord,
	output logic rdLoad
);

	typedef enum logic [1:0] {
		phaseCmd,
		phaseAdrs,
		phaseData,
		phaseIdle
	} phaseT;

	phaseT phase;
	logic [1:0] byteCount;
	logic [7:0] cmd;
	logic [15:0] adrs;
	logic [usiBusPkg::busWidth-1:0] data;

	// Read word taken straight from the bus in the cycle after the request
	assign rdWord = masterRdData;

	//--------------------------------------------------
	// Byte-position FSM and bus strobes
	//--------------------------------------------------
	always_ff @(posedge sClk) begin
		if (reset) begin
			phase <= phaseIdle;
			byteCount <= '0;
			masterAdrs <= '0;
			rdLoad <= 1'b0;
		end else begin
			// Strobes last one cycle
			masterAdrs <= '0;
			rdLoad <= masterAdrs[usiBusPkg::reqBit] && !masterAdrs[usiBusPkg::wrBit];
			if (frameStart) begin
				phase <= phaseCmd;
				byteCount <= '0;
			end else if (byteStrobe) begin
				case (phase)
					phaseCmd: begin
						cmd <= byteData;
						byteCount <= '0;
						// Unknown commands sit out the frame
						if (byteData == spiCsrPkg::cmdWrite || byteData == spiCsrPkg::cmdRead) begin
							phase <= phaseAdrs;
						end else begin
							phase <= phaseIdle;
						end
					end
					phaseAdrs: begin
						adrs <= {adrs[7:0], byteData};
						byteCount <= byteCount + 1'b1;
						if (byteCount == 2'(spiCsrPkg::adrsBytes - 1)) begin
							byteCount <= '0;
							if (cmd == spiCsrPkg::cmdRead) begin
								// Read issued now, word shifts out next
								masterAdrs[usiBusPkg::reqBit] <= 1'b1;
								masterAdrs[15:0] <= {adrs[7:0], byteData};
								phase <= phaseIdle;
							end else begin
								phase <= phaseData;
							end
						end
					end
					phaseData: begin
						data <= {data[23:0], byteData};
						byteCount <= byteCount + 1'b1;
						if (byteCount == 2'(spiCsrPkg::dataBytes - 1)) begin
							masterAdrs[usiBusPkg::reqBit] <= 1'b1;
							masterAdrs[usiBusPkg::wrBit] <= 1'b1;
							masterAdrs[15:0] <= adrs;
							masterWrData <= {data[23:0], byteData};
							phase <= phaseIdle;
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

//--- design/spiSlaveFrame.sv
`timescale 1ns/1ps

module spiSlaveFrame (
	input  logic sClk,
	input  logic reset,
	input  logic sck,
	input  logic mosi,
	input  logic cs,
	input  logic active,
	input  logic [usiBusPkg::busWidth-1:0] rdWord,
	input  logic rdLoad,
	output logic miso,
	output logic [7:0] byteData,
	output logic byteStrobe,
	output logic frameStart
);

	//--------------------------------------------------
	// Input synchronizers
	//--------------------------------------------------
	// Third stage of sck and cs for edge detect
	logic [2:0] sckSync;
	logic [2:0] csSync;
	logic [1:0] mosiSync;
	logic sckRise;
	logic sckFall;
	logic selected;
	logic [2:0] bitCount;
	logic [7:0] rxShift;
	logic [usiBusPkg::busWidth-1:0] txWord;
	// A rising edge seen since the last load
	logic shiftArm;

	always_ff @(posedge sClk) begin
		if (reset) begin
			sckSync <= '0;
			csSync <= '1;
			mosiSync <= '0;
		end else begin
			sckSync <= {sckSync[1:0], sck};
			csSync <= {csSync[1:0], cs};
			mosiSync <= {mosiSync[0], mosi};
		end
	end

	assign sckRise = sckSync[1] && !sckSync[2];
	assign sckFall = !sckSync[1] && sckSync[2];
	assign selected = active && !csSync[1];
	assign frameStart = active && csSync[2] && !csSync[1];
	assign miso = txWord[usiBusPkg::busWidth-1];

	//--------------------------------------------------
	// Receive side
	//--------------------------------------------------
	always_ff @(posedge sClk) begin
		if (reset || frameStart) begin
			bitCount <= '0;
			byteStrobe <= 1'b0;
		end else begin
			byteStrobe <= 1'b0;
			if (selected && sckRise) begin
				rxShift <= {rxShift[6:0], mosiSync[1]};
				bitCount <= bitCount + 1'b1;
				if (bitCount == 3'd7) begin
					byteData <= {rxShift[6:0], mosiSync[1]};
					byteStrobe <= 1'b1;
				end
			end
		end
	end

	//--------------------------------------------------
	// Transmit side
	//--------------------------------------------------
	// A fall ahead of the first data rise keeps the MSB in place
	always_ff @(posedge sClk) begin
		if (reset || frameStart) begin
			txWord <= '0;
			shiftArm <= 1'b0;
		end else if (rdLoad) begin
			txWord <= rdWord;
			shiftArm <= 1'b0;
		end else if (selected && sckRise) begin
			shiftArm <= 1'b1;
		end else if (selected && sckFall && shiftArm) begin
			txWord <= {txWord[usiBusPkg::busWidth-2:0], 1'b0};
		end
	end

endmodule

//--- design/spiMasterEngine.sv
`timescale 1ns/1ps

module spiMasterEngine (
	input  logic sClk,
	input  logic reset,
	input  logic cke,
	input  logic txStart,
	input  logic [7:0] txData,
	input  logic miso,
	output logic sck,
	output logic mosi,
	output logic [7:0] rxData,
	output logic doneStrobe,
	output logic busy
);

	//--------------------------------------------------
	// Byte state
	//--------------------------------------------------
	// Counts SCK edges, 16 per byte
	logic [3:0] edgeCount;
	logic [7:0] txShift;
	logic [7:0] rxShift;

	// MSB first
	assign mosi = txShift[7];
	assign rxData = rxShift;

	//--------------------------------------------------
	// Control and SCK phase
	//--------------------------------------------------
	always_ff @(posedge sClk) begin
		if (reset) begin
			busy <= 1'b0;
			sck <= 1'b0;
			edgeCount <= '0;
			doneStrobe <= 1'b0;
		end else begin
			doneStrobe <= 1'b0;
			if (!busy) begin
				// Wait for launch, SCK idles low
				if (txStart) begin
					busy <= 1'b1;
					edgeCount <= '0;
				end
			end else if (cke) begin
				sck <= !sck;
				edgeCount <= edgeCount + 1'b1;
				// Last falling edge closes the byte
				if (edgeCount == 4'd15) begin
					busy <= 1'b0;
					doneStrobe <= 1'b1;
				end
			end
		end
	end

	//--------------------------------------------------
	// Shift registers
	//--------------------------------------------------
	always_ff @(posedge sClk) begin
		if (!busy && txStart) begin
			// First bit on MOSI ahead of the first rising edge
			txShift <= txData;
		end else if (busy && cke) begin
			if (!sck) begin
				// Rising edge, sample MISO
				rxShift <= {rxShift[6:0], miso};
			end else begin
				// Falling edge, next bit out
				txShift <= {txShift[6:0], 1'b0};
			end
		end
	end

endmodule

//--- design/ckeGenerator.sv
`timescale 1ns/1ps

module ckeGenerator (
	input  logic sClk,
	input  logic reset,
	input  logic spiEn,
	input  logic [spiCsrPkg::divWidth-1:0] spiDiv,
	output logic cke
);

	logic [spiCsrPkg::divWidth-1:0] count;

	//--------------------------------------------------
	// Down-counter, one pulse per spiDiv+1 cycles
	//--------------------------------------------------
	always_ff @(posedge sClk) begin
		if (reset || !spiEn) begin
			// Reload so the first pulse comes a full period after enable
			count <= spiDiv;
			cke <= 1'b0;
		end else if (count == '0) begin
			count <= spiDiv;
			cke <= 1'b1;
		end else begin
			count <= count - 1'b1;
			cke <= 1'b0;
		end
	end

endmodule

//--- design/spiCsr.sv
`timescale 1ns/1ps

module spiCsr (
	input  logic sClk,
	input  logic reset,
	// Bus slave side
	input  logic [usiBusPkg::busWidth-1:0] csrAdrs,
	input  logic [usiBusPkg::busWidth-1:0] csrWrData,
	output logic [usiBusPkg::busWidth-1:0] csrRdData,
	// From master engine
	input  logic [7:0] rxData,
	input  logic doneStrobe,
	input  logic busy,
	// To divider and master engine
	output logic spiEn,
	output logic [spiCsrPkg::divWidth-1:0] spiDiv,
	output logic [7:0] txData,
	output logic txStart,
	output logic csLevel,
	output logic intr
);

	//--------------------------------------------------
	// Access decode
	//--------------------------------------------------
	logic [usiBusPkg::csrWidth-1:0] offset;
	logic access;
	logic wrAccess;
	logic rdAccess;
	logic txAccept;
	logic [7:0] rxReg;
	logic done;
	logic [usiBusPkg::busWidth-1:0] rdMux;

	assign offset = csrAdrs[usiBusPkg::csrLsb +: usiBusPkg::csrWidth];
	// Request bit plus matching block field
	assign access = csrAdrs[usiBusPkg::reqBit]
		&& (csrAdrs[usiBusPkg::blockLsb +: usiBusPkg::blockWidth] == usiBusPkg::blockId);
	assign wrAccess = access && csrAdrs[usiBusPkg::wrBit];
	assign rdAccess = access && !csrAdrs[usiBusPkg::wrBit];
	// Tx write dropped while a byte is in flight or just launched
	assign txAccept = wrAccess && (offset == spiCsrPkg::csrTx) && !busy && !txStart;
	assign intr = done;

	//--------------------------------------------------
	// Control registers
	//--------------------------------------------------
	always_ff @(posedge sClk) begin
		if (reset) begin
			spiEn <= 1'b0;
			spiDiv <= '0;
			csLevel <= 1'b1;
			txStart <= 1'b0;
		end else begin
			// One-cycle launch pulse
			txStart <= txAccept;
			if (wrAccess) begin
				case (offset)
					spiCsrPkg::csrCtrl: spiEn <= csrWrData[0];
					spiCsrPkg::csrDiv: spiDiv <= csrWrData[spiCsrPkg::divWidth-1:0];
					spiCsrPkg::csrCs: csLevel <= csrWrData[0];
					default: ;
				endcase
			end
		end
	end

	// Transmit byte
	always_ff @(posedge sClk) begin
		if (txAccept) begin
			txData <= csrWrData[7:0];
		end
	end

	//--------------------------------------------------
	// Receive byte and done flag
	//--------------------------------------------------
	always_ff @(posedge sClk) begin
		if (doneStrobe) begin
			rxReg <= rxData;
		end
	end

	// New completion wins over a same-cycle clear
	always_ff @(posedge sClk) begin
		if (reset) begin
			done <= 1'b0;
		end else if (doneStrobe) begin
			done <= 1'b1;
		end else if (rdAccess && (offset == spiCsrPkg::csrRx)) begin
			done <= 1'b0;
		end
	end

	//--------------------------------------------------
	// Read back
	//--------------------------------------------------
	always_comb begin
		rdMux = '0;
		case (offset)
			spiCsrPkg::csrCtrl: rdMux[0] = spiEn;
			spiCsrPkg::csrDiv: rdMux[spiCsrPkg::divWidth-1:0] = spiDiv;
			spiCsrPkg::csrTx: rdMux[7:0] = txData;
			spiCsrPkg::csrCs: rdMux[0] = csLevel;
			spiCsrPkg::csrRx: rdMux[7:0] = rxReg;
			spiCsrPkg::csrStatus: rdMux[1:0] = {busy, done};
			default: ;
		endcase
	end

	// Zero when idle so blocks can be OR-combined
	always_ff @(posedge sClk) begin
		if (reset) begin
			csrRdData <= '0;
		end else begin
			csrRdData <= rdAccess ? rdMux : '0;
		end
	end

endmodule

//--- design/spiCsrPkg.sv
package spiCsrPkg;

	//--------------------------------------------------
	// Field widths
	//--------------------------------------------------
	// SCK divider register width
	localparam int divWidth = 16;

	//--------------------------------------------------
	// Register offsets
	//--------------------------------------------------
	// Bit 0 enable
	localparam logic [usiBusPkg::csrWidth-1:0] csrCtrl = 8'h00;
	// Divider value
	localparam logic [usiBusPkg::csrWidth-1:0] csrDiv = 8'h04;
	// Transmit byte, write starts a transfer
	localparam logic [usiBusPkg::csrWidth-1:0] csrTx = 8'h08;
	// Bit 0 chip select level
	localparam logic [usiBusPkg::csrWidth-1:0] csrCs = 8'h0C;
	// Received byte, read clears done
	localparam logic [usiBusPkg::csrWidth-1:0] csrRx = 8'h10;
	// Bit 0 done, bit 1 busy
	localparam logic [usiBusPkg::csrWidth-1:0] csrStatus = 8'h14;

	//--------------------------------------------------
	// Slave frame commands
	//--------------------------------------------------
	localparam logic [7:0] cmdWrite = 8'h02;
	localparam logic [7:0] cmdRead = 8'h03;

	// Byte counts after the command byte
	localparam int adrsBytes = 2;
	localparam int dataBytes = 4;

endpackage

//--- design/usiBusPkg.sv
package usiBusPkg;

	//--------------------------------------------------
	// Bus word layout
	//--------------------------------------------------
	// Width of every address and data word on the bus
	localparam int busWidth = 32;

	// Request marker, valid for this cycle only
	localparam int reqBit = 31;
	// Set for write, clear for read
	localparam int wrBit = 30;

	// Block select field
	localparam int blockLsb = 8;
	localparam int blockWidth = 8;

	// Register offset inside a block
	localparam int csrLsb = 0;
	localparam int csrWidth = 8;

	//--------------------------------------------------
	// Block identity
	//--------------------------------------------------
	// Select value this SPI block answers to
	localparam logic [blockWidth-1:0] blockId = 8'h03;

endpackage
